// ==== verilog/frontend_settings.svh ====
// fetch front end configuration

`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// address and pc width
`define FE_XLEN 32

// 16-bit half-words per fetch line
`define FE_LINE_HW 4

// first pc out of reset
`define FE_RESET_PC 32'h0000_1000

// fetch target queue entries, also the request credit limit
`define FE_FTQ_DEPTH 4

// decoded instruction queue entries
`define FE_IQ_DEPTH 8

`endif

// ==== verilog/frontend_pkg.sv ====
// fetch front end shared types

`include "frontend_settings.svh"

package frontend_pkg;

    // one line returned by the instruction memory
    typedef struct packed {
        logic [`FE_XLEN-1:0]              pc;   // line base plus start offset
        logic [`FE_LINE_HW-1:0][15:0]     data; // half-word 0 at the lowest address
    } fetch_line_t;

    // aligned instruction, not yet decoded
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        logic [31:0]         ir;         // upper half zero for 16-bit forms
        logic                compressed;
    } raw_inst_t;

    // decoded instruction leaving the front end
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        logic [31:0]         ir;
        logic                compressed;
        logic                is_branch;  // conditional, incl. c.beqz/c.bnez
        logic                is_jal;     // jal and c.j
        logic                is_jalr;    // jalr, c.jr, c.jalr
        logic [`FE_XLEN-1:0] target;     // static target or fall-through
    } inst_t;

    // fetch restart request
    typedef struct packed {
        logic                valid;
        logic [`FE_XLEN-1:0] pc;
    } redirect_t;

endpackage

// ==== verilog/sync_fifo.sv ====
// synchronous queue, valid/ready on both sides

`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  payload_t               in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output payload_t               out_data,
    output logic [$clog2(DEPTH):0] count
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    payload_t         mem [DEPTH]; // entry storage
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic             push;
    logic             pop;

    // circular increment, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = count < CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr]; // head straight from storage
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

// ==== verilog/fetch_pc_gen.sv ====
// fetch address generator and memory request port

`timescale 1ns/1ps
`include "frontend_settings.svh"

module fetch_pc_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  frontend_pkg::redirect_t     be_redirect,
    input  frontend_pkg::redirect_t     fe_redirect,
    output logic                        imem_req_valid,
    input  logic                        imem_req_ready,
    output logic [`FE_XLEN-1:0]         imem_req_addr,
    input  logic                        imem_resp_valid,
    input  logic [16*`FE_LINE_HW-1:0]   imem_resp_data,
    input  logic                        ftq_pop,
    output logic                        line_valid,
    output frontend_pkg::fetch_line_t   line
);
    localparam int OFF_W    = $clog2(2 * `FE_LINE_HW); // byte offset bits within a line
    localparam int PQ_DEPTH = 2 * `FE_FTQ_DEPTH;       // room for dropped plus live requests
    localparam int PQ_W     = $clog2(PQ_DEPTH);
    localparam int PEND_W   = PQ_W + 1;
    localparam int CR_W     = $clog2(`FE_FTQ_DEPTH) + 1;

    logic                fetch_on;             // low for the first cycle out of reset
    logic [`FE_XLEN-1:0] fetch_pc;             // next fetch pc, may carry a start offset
    logic [`FE_XLEN-1:0] pc_queue [PQ_DEPTH];  // pcs of requests in flight, oldest first
    logic [PQ_W-1:0]     pq_rd;
    logic [PQ_W-1:0]     pq_wr;
    logic [PEND_W-1:0]   pend;                 // all requests still waiting for data
    logic [PEND_W-1:0]   pend_next;
    logic [PEND_W-1:0]   drop;                 // responses left to discard
    logic [CR_W-1:0]     credit;               // live requests plus lines held in the ftq
    logic                flush;
    logic [`FE_XLEN-1:0] flush_pc;
    logic                req_fire;
    logic                resp_drop;

    // backend redirect has priority
    assign flush    = be_redirect.valid | fe_redirect.valid;
    assign flush_pc = be_redirect.valid ? be_redirect.pc : fe_redirect.pc;

    assign imem_req_valid = fetch_on && (credit < CR_W'(`FE_FTQ_DEPTH))
                            && (pend < PEND_W'(PQ_DEPTH));
    assign imem_req_addr  = {fetch_pc[`FE_XLEN-1:OFF_W], {OFF_W{1'b0}}};
    assign req_fire       = imem_req_valid && imem_req_ready;
    assign resp_drop      = drop != '0;
    assign pend_next      = pend + PEND_W'(req_fire) - PEND_W'(imem_resp_valid);

    // in-order responses pair with the oldest pc
    assign line_valid = imem_resp_valid && !resp_drop;
    assign line.pc    = pc_queue[pq_rd];
    assign line.data  = imem_resp_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_on <= 1'b0;
            fetch_pc <= `FE_RESET_PC;
        end else begin
            fetch_on <= 1'b1;
            if (flush) begin
                fetch_pc <= flush_pc; // offset rides along to the first line
            end else if (req_fire) begin
                fetch_pc <= imem_req_addr + `FE_XLEN'(2 * `FE_LINE_HW);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend   <= '0;
            drop   <= '0;
            credit <= '0;
            pq_rd  <= '0;
            pq_wr  <= '0;
        end else begin
            pend <= pend_next;
            if (req_fire) begin
                pq_wr <= pq_wr + 1'b1;
            end
            if (imem_resp_valid) begin
                pq_rd <= pq_rd + 1'b1;
            end
            if (flush) begin
                drop   <= pend_next; // everything still out is stale
                credit <= '0;
            end else begin
                if (imem_resp_valid && resp_drop) begin
                    drop <= drop - 1'b1;
                end
                credit <= credit + CR_W'(req_fire) - CR_W'(ftq_pop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            pc_queue[pq_wr] <= fetch_pc;
        end
    end

endmodule

// ==== verilog/inst_align.sv ====
// fetch line to instruction alignment

`timescale 1ns/1ps
`include "frontend_settings.svh"

module inst_align (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      line_valid,
    output logic                      line_ready,
    input  frontend_pkg::fetch_line_t line,
    output logic                      raw_valid,
    input  logic                      raw_ready,
    output frontend_pkg::raw_inst_t   raw
);
    localparam int HW_W = $clog2(`FE_LINE_HW);
    localparam logic [HW_W-1:0] LAST = HW_W'(`FE_LINE_HW - 1);

    logic                started;     // cursor belongs to the current head line
    logic [HW_W-1:0]     cursor;
    logic                carry_valid;
    logic [15:0]         carry_hw;    // low half of a split 32-bit instruction
    logic [`FE_XLEN-1:0] carry_pc;

    logic [HW_W-1:0]     cur;
    logic [15:0]         hw0;
    logic [15:0]         hw1;
    logic                use_carry;
    logic                is_16;
    logic                split;       // 32-bit start in the last slot
    logic                stash;
    logic                fire;
    logic [HW_W:0]       next_pos;
    logic [`FE_XLEN-1:0] slot_pc;

    // a fresh line starts at the offset in its pc
    assign cur     = started ? cursor : line.pc[HW_W:1];
    assign hw0     = line.data[cur];
    assign hw1     = (cur == LAST) ? 16'h0 : line.data[cur + 1'b1];
    assign slot_pc = {line.pc[`FE_XLEN-1:HW_W+1], cur, 1'b0};

    // carry only joins the next sequential line
    assign use_carry = carry_valid && (line.pc == carry_pc + `FE_XLEN'(2));
    assign is_16     = hw0[1:0] != 2'b11;
    assign split     = !use_carry && !is_16 && (cur == LAST);
    assign stash     = line_valid && split;

    always_comb begin
        if (use_carry) begin
            raw.pc         = carry_pc;
            raw.ir         = {line.data[0], carry_hw};
            raw.compressed = 1'b0;
            next_pos       = (HW_W+1)'(1);
        end else begin
            raw.pc         = slot_pc;
            raw.ir         = is_16 ? {16'h0, hw0} : {hw1, hw0};
            raw.compressed = is_16;
            next_pos       = {1'b0, cur} + (is_16 ? (HW_W+1)'(1) : (HW_W+1)'(2));
        end
    end

    assign raw_valid  = line_valid && !split;
    assign fire       = raw_valid && raw_ready;
    assign line_ready = (fire && (next_pos >= (HW_W+1)'(`FE_LINE_HW))) || stash;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            started     <= 1'b0;
            cursor      <= '0;
            carry_valid <= 1'b0;
        end else begin
            if (line_ready) begin
                started <= 1'b0; // next head starts from its own offset
            end else if (fire) begin
                started <= 1'b1;
                cursor  <= next_pos[HW_W-1:0];
            end
            if (stash) begin
                carry_valid <= 1'b1;
            end else if (fire && use_carry) begin
                carry_valid <= 1'b0;
            end else if (line_valid && carry_valid && !use_carry) begin
                carry_valid <= 1'b0; // non-sequential line, stale half
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stash) begin
            carry_hw <= hw0;
            carry_pc <= slot_pc;
        end
    end

endmodule

// ==== verilog/predecode.sv ====
// branch pre-decode and static jump redirect

`timescale 1ns/1ps
`include "frontend_settings.svh"

module predecode (
    input  logic                    raw_valid,
    output logic                    raw_ready,
    input  frontend_pkg::raw_inst_t raw,
    output logic                    inst_valid,
    input  logic                    inst_ready,
    output frontend_pkg::inst_t     inst,
    output frontend_pkg::redirect_t fe_redirect
);
    localparam int XLEN = `FE_XLEN;

    logic [31:0]     ir;
    logic [6:0]      opcode;
    logic            op_branch;
    logic            op_jal;
    logic            op_jalr;
    logic            c_j;
    logic            c_bz;       // c.beqz and c.bnez
    logic            c_jr;       // c.jr and c.jalr
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_cj;
    logic [XLEN-1:0] imm_cb;
    logic [XLEN-1:0] next_pc;

    assign ir     = raw.ir;
    assign opcode = ir[6:0];

    // 32-bit control transfers
    assign op_branch = !raw.compressed && (opcode == 7'b1100011);
    assign op_jal    = !raw.compressed && (opcode == 7'b1101111);
    assign op_jalr   = !raw.compressed && (opcode == 7'b1100111);

    // compressed forms, quadrant in ir[1:0]
    assign c_j  = raw.compressed && (ir[1:0] == 2'b01) && (ir[15:13] == 3'b101);
    assign c_bz = raw.compressed && (ir[1:0] == 2'b01) && (ir[15:14] == 2'b11);
    assign c_jr = raw.compressed && (ir[1:0] == 2'b10) && (ir[15:13] == 3'b100)
                  && (ir[6:2] == 5'd0) && (ir[11:7] != 5'd0); // rs1 of zero is c.ebreak

    // sign-extended immediates
    assign imm_b  = {{(XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_j  = {{(XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    assign imm_cj = {{(XLEN-11){ir[12]}}, ir[8], ir[10:9], ir[6], ir[7], ir[2],
                     ir[11], ir[5:3], 1'b0};
    assign imm_cb = {{(XLEN-8){ir[12]}}, ir[6:5], ir[2], ir[11:10], ir[4:3], 1'b0};

    assign next_pc = raw.pc + (raw.compressed ? XLEN'(2) : XLEN'(4));

    always_comb begin
        inst.pc         = raw.pc;
        inst.ir         = raw.ir;
        inst.compressed = raw.compressed;
        inst.is_branch  = op_branch || c_bz;
        inst.is_jal     = op_jal || c_j;
        inst.is_jalr    = op_jalr || c_jr;
        if (op_branch) begin
            inst.target = raw.pc + imm_b;
        end else if (op_jal) begin
            inst.target = raw.pc + imm_j;
        end else if (c_j) begin
            inst.target = raw.pc + imm_cj;
        end else if (c_bz) begin
            inst.target = raw.pc + imm_cb;
        end else if (op_jalr || c_jr) begin
            inst.target = '0; // register target, unknown here
        end else begin
            inst.target = next_pc;
        end
    end

    // straight pass, no stage register
    assign inst_valid = raw_valid;
    assign raw_ready  = inst_ready;

    // jumps taken as soon as the queue accepts them
    assign fe_redirect.valid = raw_valid && inst_ready && inst.is_jal;
    assign fe_redirect.pc    = inst.target;

endmodule

// ==== verilog/frontend_top.sv ====
// instruction fetch front end, top level

`timescale 1ns/1ps
`include "frontend_settings.svh"

module frontend_top (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       imem_req_valid,
    input  logic                       imem_req_ready,
    output logic [`FE_XLEN-1:0]        imem_req_addr,
    input  logic                       imem_resp_valid,
    input  logic [16*`FE_LINE_HW-1:0]  imem_resp_data,
    input  frontend_pkg::redirect_t    be_redirect,
    output logic                       out_valid,
    input  logic                       out_ready,
    output frontend_pkg::inst_t        out_inst
);
    frontend_pkg::redirect_t   fe_redirect;  // jal/c.j restart from pre-decode
    frontend_pkg::fetch_line_t fetched_line; // memory response with its pc
    frontend_pkg::fetch_line_t head_line;    // ftq head
    frontend_pkg::raw_inst_t   raw;
    frontend_pkg::inst_t       inst;
    logic                      fetched_valid;
    logic                      head_valid;
    logic                      head_ready;
    logic                      ftq_pop;
    logic                      raw_valid;
    logic                      raw_ready;
    logic                      inst_valid;
    logic                      inst_ready;
    logic                      line_flush;

    assign line_flush = be_redirect.valid | fe_redirect.valid;
    assign ftq_pop    = head_valid && head_ready;

    fetch_pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .be_redirect    (be_redirect),
        .fe_redirect    (fe_redirect),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_req_addr  (imem_req_addr),
        .imem_resp_valid(imem_resp_valid),
        .imem_resp_data (imem_resp_data),
        .ftq_pop        (ftq_pop),
        .line_valid     (fetched_valid),
        .line           (fetched_line)
    );

    // space is guaranteed by the request credits
    sync_fifo #(
        .payload_t(frontend_pkg::fetch_line_t),
        .DEPTH    (`FE_FTQ_DEPTH)
    ) u_ftq (
        .clk      (clk),
        .rst      (rst),
        .flush    (line_flush),
        .in_valid (fetched_valid),
        .in_ready (),
        .in_data  (fetched_line),
        .out_valid(head_valid),
        .out_ready(head_ready),
        .out_data (head_line),
        .count    ()
    );

    inst_align u_align (
        .clk       (clk),
        .rst       (rst),
        .flush     (line_flush),
        .line_valid(head_valid),
        .line_ready(head_ready),
        .line      (head_line),
        .raw_valid (raw_valid),
        .raw_ready (raw_ready),
        .raw       (raw)
    );

    predecode u_predecode (
        .raw_valid  (raw_valid),
        .raw_ready  (raw_ready),
        .raw        (raw),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .fe_redirect(fe_redirect)
    );

    // only a backend redirect empties the decoded instructions
    sync_fifo #(
        .payload_t(frontend_pkg::inst_t),
        .DEPTH    (`FE_IQ_DEPTH)
    ) u_iq (
        .clk      (clk),
        .rst      (rst),
        .flush    (be_redirect.valid),
        .in_valid (inst_valid),
        .in_ready (inst_ready),
        .in_data  (inst),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data (out_inst),
        .count    ()
    );

endmodule

// ==== bench/frontend_tb_model.svh ====
// program image and reference walk model

`ifndef FRONTEND_TB_MODEL_SVH
`define FRONTEND_TB_MODEL_SVH

// xorshift32 step
function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// image wraps every 4 KiB
function automatic logic [15:0] hw_at(input logic [`FE_XLEN-1:0] addr);
    return mem[addr[11:1]];
endfunction

function automatic logic [16*`FE_LINE_HW-1:0] line_at(input logic [`FE_XLEN-1:0] addr);
    logic [16*`FE_LINE_HW-1:0] data;
    for (int i = 0; i < `FE_LINE_HW; i++) begin
        data[16*i +: 16] = hw_at(addr + 2 * i); // lowest address in the low bits
    end
    return data;
endfunction

// random mix of plain instructions and control transfers
task automatic fill_memory();
    logic [31:0] r;
    logic [31:0] w;
    int          i;
    i = 0;
    while (i < 2048) begin
        r = next_random();
        w = next_random();
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: w = {16'h0, w[15:2], 2'b00}; // quadrant 0
            4'd9:    w[6:0] = 7'b1100011;                      // branch
            4'd10:   w[6:0] = 7'b1101111;                      // jal
            4'd11:   w[6:0] = 7'b1100111;                      // jalr
            4'd12:   w = {16'h0, 3'b101, w[12:2], 2'b01};      // c.j
            4'd13:   w = {16'h0, 2'b11, w[13:2], 2'b01};       // c.beqz, c.bnez
            4'd14:   w = {16'h0, 3'b100, w[12], w[11:7] | 5'd1, 5'd0, 2'b10}; // c.jr, c.jalr
            default: w[6:0] = 7'b0010011;                      // op-imm
        endcase
        if (w[1:0] != 2'b11) begin
            mem[i] = w[15:0];
            i++;
        end else if (i < 2047) begin
            mem[i]     = w[15:0];
            mem[i + 1] = w[31:16];
            i += 2;
        end
    end
endtask

// v holds no bits above msb
function automatic logic [31:0] sign_extend(input logic [31:0] v, input int msb);
    logic [31:0] m;
    m = 32'h1 << msb;
    return (v ^ m) - m;
endfunction

// expected decode of the instruction at pc
function automatic frontend_pkg::inst_t expect_at(input logic [`FE_XLEN-1:0] pc);
    frontend_pkg::inst_t e;
    logic [31:0]         ir;
    logic [31:0]         imm;
    ir           = {hw_at(pc + 2), hw_at(pc)};
    imm          = '0;
    e            = '0;
    e.pc         = pc;
    e.compressed = ir[1:0] != 2'b11;
    if (e.compressed) begin
        ir[31:16] = 16'h0;
    end
    e.ir     = ir;
    e.target = pc + (e.compressed ? 32'd2 : 32'd4);
    if (!e.compressed && ir[6:0] == 7'b1100011) begin
        e.is_branch = 1'b1;
        imm[12]     = ir[31];
        imm[10:5]   = ir[30:25];
        imm[4:1]    = ir[11:8];
        imm[11]     = ir[7];
        e.target    = pc + sign_extend(imm, 12);
    end else if (!e.compressed && ir[6:0] == 7'b1101111) begin
        e.is_jal    = 1'b1;
        imm[20]     = ir[31];
        imm[10:1]   = ir[30:21];
        imm[11]     = ir[20];
        imm[19:12]  = ir[19:12];
        e.target    = pc + sign_extend(imm, 20);
    end else if (!e.compressed && ir[6:0] == 7'b1100111) begin
        e.is_jalr   = 1'b1;
        e.target    = '0;
    end else if (ir[1:0] == 2'b01 && ir[15:13] == 3'b101) begin
        e.is_jal    = 1'b1;   // c.j
        imm[11]     = ir[12];
        imm[4]      = ir[11];
        imm[9:8]    = ir[10:9];
        imm[10]     = ir[8];
        imm[6]      = ir[7];
        imm[7]      = ir[6];
        imm[3:1]    = ir[5:3];
        imm[5]      = ir[2];
        e.target    = pc + sign_extend(imm, 11);
    end else if (ir[1:0] == 2'b01 && ir[15:14] == 2'b11) begin
        e.is_branch = 1'b1;   // c.beqz, c.bnez
        imm[8]      = ir[12];
        imm[4:3]    = ir[11:10];
        imm[7:6]    = ir[6:5];
        imm[2:1]    = ir[4:3];
        imm[5]      = ir[2];
        e.target    = pc + sign_extend(imm, 8);
    end else if (ir[1:0] == 2'b10 && ir[15:13] == 3'b100 && ir[6:2] == 5'd0
                 && ir[11:7] != 5'd0) begin
        e.is_jalr   = 1'b1;   // c.jr, c.jalr
        e.target    = '0;
    end
    return e;
endfunction

// static prediction, only jal and c.j leave the sequential path
function automatic logic [`FE_XLEN-1:0] successor_pc(input frontend_pkg::inst_t e);
    return e.is_jal ? e.target : e.pc + (e.compressed ? 32'd2 : 32'd4);
endfunction

`endif

// ==== bench/frontend_tb.sv ====
// fetch front end testbench

`timescale 1ns/1ps
`include "frontend_settings.svh"

module frontend_tb;
    localparam int NUM_INSTS  = 3000;
    localparam int MAX_CYCLES = NUM_INSTS * 40;
    localparam logic [`FE_XLEN-1:0] LINE_MASK = ~`FE_XLEN'(2 * `FE_LINE_HW - 1);

    logic                      clk;
    logic                      rst;
    logic                      imem_req_valid;
    logic                      imem_req_ready;
    logic [`FE_XLEN-1:0]       imem_req_addr;
    logic                      imem_resp_valid;
    logic [16*`FE_LINE_HW-1:0] imem_resp_data;
    frontend_pkg::redirect_t   be_redirect;
    logic                      out_valid;
    logic                      out_ready;
    frontend_pkg::inst_t       out_inst;

    logic [15:0]         mem [2048];     // 4 KiB program image
    logic [31:0]         rng_state;
    logic [`FE_XLEN-1:0] model_pc;       // pc of the next expected output
    logic [`FE_XLEN-1:0] resp_addr [$];  // accepted requests, oldest first
    int                  resp_due [$];   // cycle each response goes out
    int                  last_due;
    int                  cyc;
    int                  checked;
    bit                  first_req;

    `include "frontend_tb_model.svh"

    frontend_top uut (
        .clk            (clk),
        .rst            (rst),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_req_addr  (imem_req_addr),
        .imem_resp_valid(imem_resp_valid),
        .imem_resp_data (imem_resp_data),
        .be_redirect    (be_redirect),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_inst       (out_inst)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_inst(input frontend_pkg::inst_t got, input frontend_pkg::inst_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf(
                "[ERROR] %0t: got pc %h ir %h flags %b target %h, expected pc %h ir %h flags %b target %h",
                $time, got.pc, got.ir, {got.compressed, got.is_branch, got.is_jal, got.is_jalr},
                got.target, exp.pc, exp.ir, {exp.compressed, exp.is_branch, exp.is_jal,
                exp.is_jalr}, exp.target));
        end
    endtask

    task automatic check_addr(input logic [`FE_XLEN-1:0] got, input logic [`FE_XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // drive at the falling edge, sample 1 ns later
    task automatic run_cycle();
        logic [31:0]         r;
        logic [31:0]         pc_rand;
        int                  due;
        frontend_pkg::inst_t exp;
        r       = next_random();
        pc_rand = next_random();
        cyc++;
        if (cyc > MAX_CYCLES) begin
            stop_on_failure("timeout: the front end stopped delivering instructions");
        end
        imem_resp_valid = 1'b0;
        if (resp_due.size() != 0 && resp_due[0] <= cyc) begin
            imem_resp_valid = 1'b1;
            imem_resp_data  = line_at(resp_addr.pop_front());
            void'(resp_due.pop_front());
        end
        imem_req_ready = r[1:0] != 2'b00;
        out_ready      = r[3:2] != 2'b00;
        be_redirect    = '0;
        if (r[13:6] == 8'd0 && !first_req) begin // roughly one cycle in 256
            be_redirect.valid = 1'b1;
            be_redirect.pc    = {pc_rand[`FE_XLEN-1:1], 1'b0};
            out_ready         = 1'b0;            // output queue flushes this cycle
            model_pc          = be_redirect.pc;
        end
        #1;
        if (cyc == 1) begin
            check_bit(imem_req_valid, 1'b0, "imem_req_valid in the first cycle after reset");
        end
        if (imem_req_valid && imem_req_ready) begin
            if (first_req) begin
                check_addr(imem_req_addr, `FE_RESET_PC & LINE_MASK, "first request address");
                first_req = 1'b0;
            end
            due = cyc + 1 + int'(r[18:16]) % 6;  // 1 to 6 cycles
            if (due <= last_due) begin
                due = last_due + 1;              // keep responses in order
            end
            last_due = due;
            resp_addr.push_back(imem_req_addr);
            resp_due.push_back(due);
        end
        if (out_valid && out_ready) begin
            exp = expect_at(model_pc);
            check_inst(out_inst, exp);
            model_pc = successor_pc(exp);
            checked++;
        end
        @(negedge clk);
    endtask

    initial begin
        rst             = 1'b1;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        be_redirect     = '0;
        out_ready       = 1'b0;
        rng_state       = 32'd7492;
        model_pc        = `FE_RESET_PC;
        last_due        = 0;
        cyc             = 0;
        checked         = 0;
        first_req       = 1'b1;
        fill_memory();
        repeat (8) @(negedge clk);
        check_bit(out_valid, 1'b0, "out_valid after reset");
        check_bit(imem_req_valid, 1'b0, "imem_req_valid after reset");
        check_bit(uut.fe_redirect.valid, 1'b0, "fe_redirect.valid after reset");
        rst = 1'b0;
        while (checked < NUM_INSTS) begin
            run_cycle();
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== frontend_top.f ====
+incdir+verilog
+incdir+bench
verilog/frontend_pkg.sv
verilog/sync_fifo.sv
verilog/fetch_pc_gen.sv
verilog/inst_align.sv
verilog/predecode.sv
verilog/frontend_top.sv
bench/frontend_tb.sv
